//--- flist.f
source/ice_pkg.sv
source/ice_uart.sv
source/ice_frame_decoder.sv
source/ice_basics_int.sv
source/ice_gpio_int.sv
source/ice_resp_arbiter.sv
source/ice_bus.sv
tb/ice_bus_sva.sv
tb/ice_bus_tb.sv

//--- source/ice_basics_int.sv
`timescale 1ns/1ps

module ice_basics_int #(
	parameter logic [ice_pkg::baud_w-1:0] default_baud_div = 8
) (
	input  logic                       reset,
	input  logic                       clk,
	input  logic [ice_pkg::char_w-1:0] ma_addr,
	input  logic [ice_pkg::char_w-1:0] ma_id,
	input  logic [ice_pkg::char_w-1:0] ma_data,
	input  logic                       ma_data_valid,
	input  logic                       ma_frame_valid,
	output logic [ice_pkg::char_w-1:0] sl_data,
	output logic                       sl_tail,
	output logic                       sl_arb_request,
	input  logic                       sl_arb_grant,
	input  logic                       sl_latch,
	output logic [ice_pkg::baud_w-1:0] baud_div
);
	import ice_pkg::*;

	typedef enum logic [1:0] {rep_version, rep_baud, rep_nak} reply_t;

	logic              frame_q;
	logic              frame_end;
	logic              known;
	logic              claim;
	reply_t            reply;
	logic [char_w-1:0] reply_id;
	logic [2:0]        rsp_idx;
	logic              byte_idx;
	logic [baud_w-1:0] new_div;
	logic [char_w-1:0] rsp_byte;
	logic              rsp_last;

	assign frame_end = frame_q && !ma_frame_valid;
	assign known = ma_addr inside {type_version, type_baud, type_gpio_wr, type_gpio_rd};
	// Own types plus anything nobody else answers
	assign claim = frame_end && !sl_arb_request &&
		(ma_addr == type_version || ma_addr == type_baud || !known);

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			frame_q        <= 1'b0;
			byte_idx       <= 1'b0;
			sl_arb_request <= 1'b0;
			reply          <= rep_nak;
			rsp_idx        <= '0;
			baud_div       <= default_baud_div;
		end else begin
			frame_q <= ma_frame_valid;
			if (!ma_frame_valid) begin
				byte_idx <= 1'b0;
			end else if (ma_data_valid && ma_addr == type_baud) begin
				byte_idx <= 1'b1;
			end
			if (claim) begin
				sl_arb_request <= 1'b1;
				rsp_idx        <= '0;
				if (ma_addr == type_version) begin
					reply <= rep_version;
				end else if (ma_addr == type_baud) begin
					reply <= rep_baud;
				end else begin
					reply <= rep_nak;
				end
			end else if (sl_latch && sl_arb_grant) begin
				if (rsp_last) begin
					sl_arb_request <= 1'b0;
					// New rate once the ACK tail is handed over
					if (reply == rep_baud) begin
						baud_div <= new_div;
					end
				end else begin
					rsp_idx <= rsp_idx + 1'b1;
				end
			end
		end
	end

	// Divider arrives high byte first
	always_ff @(posedge reset) begin
		if (claim) begin
			reply_id <= ma_id;
		end
		if (ma_frame_valid && ma_data_valid && ma_addr == type_baud) begin
			if (!byte_idx) begin
				new_div[baud_w-1:char_w] <= ma_data;
			end else begin
				new_div[char_w-1:0] <= ma_data;
			end
		end
	end

	// Reply bytes by index
	always_comb begin
		case (rsp_idx)
			3'd0:    rsp_byte = (reply == rep_nak) ? resp_nak : resp_ack;
			3'd1:    rsp_byte = reply_id;
			3'd2:    rsp_byte = (reply == rep_version) ? char_w'(2) : '0;
			3'd3:    rsp_byte = version_major;
			default: rsp_byte = version_minor;
		endcase
	end

	assign rsp_last = (reply == rep_version) ? (rsp_idx == 3'd4) : (rsp_idx == 3'd2);
	assign sl_data  = sl_arb_grant ? rsp_byte : '0;
	assign sl_tail  = sl_arb_grant && rsp_last;

endmodule

//--- source/ice_bus.sv
`timescale 1ns/1ps

module ice_bus #(
	parameter int                         num_dev          = 2,
	parameter int                         gpio_w           = 8,
	parameter logic [ice_pkg::baud_w-1:0] default_baud_div = 8
) (
	input  logic              reset,
	input  logic              clk,
	input  logic              rx_in,
	output logic              tx_out,
	input  logic [gpio_w-1:0] gpio_in,
	output logic [gpio_w-1:0] gpio_out,
	output logic [gpio_w-1:0] gpio_oe
);
	import ice_pkg::*;

	// UART side
	logic [baud_w-1:0] baud_div;
	logic [char_w-1:0] rx_data, tx_data;
	logic              rx_latch, tx_latch, tx_empty;
	// Master bus
	logic [char_w-1:0] ma_addr, ma_id, ma_data;
	logic              ma_data_valid, ma_frame_valid;
	// Slave bus, basics is requester 0 and GPIO requester 1
	logic [num_dev-1:0]             sl_arb_request, sl_arb_grant, sl_tail;
	logic [num_dev-1:0][char_w-1:0] sl_data;
	logic                           sl_latch;

	ice_uart u_uart (.*);

	ice_frame_decoder u_decoder (.*);

	ice_basics_int #(.default_baud_div(default_baud_div)) u_basics (.sl_data(sl_data[0]),
		.sl_tail(sl_tail[0]), .sl_arb_request(sl_arb_request[0]),
		.sl_arb_grant(sl_arb_grant[0]), .*);

	ice_gpio_int #(.gpio_w(gpio_w)) u_gpio (.sl_data(sl_data[1]), .sl_tail(sl_tail[1]),
		.sl_arb_request(sl_arb_request[1]), .sl_arb_grant(sl_arb_grant[1]), .*);

	ice_resp_arbiter #(.num_dev(num_dev)) u_arbiter (.*);

endmodule

//--- source/ice_frame_decoder.sv
`timescale 1ns/1ps

module ice_frame_decoder (
	input  logic                       reset,
	input  logic                       clk,
	input  logic [ice_pkg::char_w-1:0] rx_data,
	input  logic                       rx_latch,
	output logic [ice_pkg::char_w-1:0] ma_addr,
	output logic [ice_pkg::char_w-1:0] ma_id,
	output logic [ice_pkg::char_w-1:0] ma_data,
	output logic                       ma_data_valid,
	output logic                       ma_frame_valid
);
	import ice_pkg::*;

	typedef enum logic [1:0] {st_type, st_id, st_len, st_data} state_t;

	state_t            state;
	logic [char_w-1:0] remaining;
	// Drop frame valid on the next cycle
	logic              frame_close;

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			state          <= st_type;
			remaining      <= '0;
			frame_close    <= 1'b0;
			ma_data_valid  <= 1'b0;
			ma_frame_valid <= 1'b0;
		end else begin
			ma_data_valid <= 1'b0;
			if (frame_close) begin
				frame_close    <= 1'b0;
				ma_frame_valid <= 1'b0;
			end
			if (rx_latch) begin
				case (state)
					st_type: state <= st_id;
					st_id:   state <= st_len;
					st_len: begin
						remaining      <= rx_data;
						ma_frame_valid <= 1'b1;
						// Empty frame, valid for one cycle
						if (rx_data == '0) begin
							frame_close <= 1'b1;
							state       <= st_type;
						end else begin
							state <= st_data;
						end
					end
					st_data: begin
						ma_data_valid <= 1'b1;
						remaining     <= remaining - 1'b1;
						if (remaining == char_w'(1)) begin
							frame_close <= 1'b1;
							state       <= st_type;
						end
					end
					default: state <= st_type;
				endcase
			end
		end
	end

	// Type and id held for the whole frame
	always_ff @(posedge reset) begin
		if (rx_latch) begin
			case (state)
				st_type: ma_addr <= rx_data;
				st_id:   ma_id   <= rx_data;
				st_data: ma_data <= rx_data;
				default: ;
			endcase
		end
	end

endmodule

//--- source/ice_gpio_int.sv
`timescale 1ns/1ps

module ice_gpio_int #(
	parameter int gpio_w = 8
) (
	input  logic                       reset,
	input  logic                       clk,
	input  logic [ice_pkg::char_w-1:0] ma_addr,
	input  logic [ice_pkg::char_w-1:0] ma_id,
	input  logic [ice_pkg::char_w-1:0] ma_data,
	input  logic                       ma_data_valid,
	input  logic                       ma_frame_valid,
	output logic [ice_pkg::char_w-1:0] sl_data,
	output logic                       sl_tail,
	output logic                       sl_arb_request,
	input  logic                       sl_arb_grant,
	input  logic                       sl_latch,
	input  logic [gpio_w-1:0]          gpio_in,
	output logic [gpio_w-1:0]          gpio_out,
	output logic [gpio_w-1:0]          gpio_oe
);
	import ice_pkg::*;

	logic [gpio_w-1:0] gpio_meta;
	logic [gpio_w-1:0] gpio_sync;
	logic [gpio_w-1:0] snapshot;
	logic              frame_q;
	logic              frame_end;
	logic              claim;
	logic              is_read;
	logic              byte_idx;
	logic [1:0]        rsp_idx;
	logic [char_w-1:0] reply_id;
	logic [char_w-1:0] rsp_byte;
	logic              rsp_last;

	assign frame_end = frame_q && !ma_frame_valid;
	assign claim = frame_end && !sl_arb_request &&
		(ma_addr == type_gpio_wr || ma_addr == type_gpio_rd);

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			frame_q        <= 1'b0;
			byte_idx       <= 1'b0;
			gpio_oe        <= '0;
			gpio_out       <= '0;
			sl_arb_request <= 1'b0;
			is_read        <= 1'b0;
			rsp_idx        <= '0;
		end else begin
			frame_q <= ma_frame_valid;
			// Byte 0 direction, byte 1 level
			if (!ma_frame_valid) begin
				byte_idx <= 1'b0;
			end else if (ma_data_valid && ma_addr == type_gpio_wr) begin
				byte_idx <= 1'b1;
				if (!byte_idx) begin
					gpio_oe <= gpio_w'(ma_data);
				end else begin
					gpio_out <= gpio_w'(ma_data);
				end
			end
			if (claim) begin
				sl_arb_request <= 1'b1;
				rsp_idx        <= '0;
				is_read        <= (ma_addr == type_gpio_rd);
			end else if (sl_latch && sl_arb_grant) begin
				if (rsp_last) begin
					sl_arb_request <= 1'b0;
				end else begin
					rsp_idx <= rsp_idx + 1'b1;
				end
			end
		end
	end

	// Pins are asynchronous to the bus clock
	always_ff @(posedge reset) begin
		gpio_meta <= gpio_in;
		gpio_sync <= gpio_meta;
		if (claim) begin
			reply_id <= ma_id;
		end
		if (claim && ma_addr == type_gpio_rd) begin
			snapshot <= gpio_sync;
		end
	end

	always_comb begin
		case (rsp_idx)
			2'd0:    rsp_byte = resp_ack;
			2'd1:    rsp_byte = reply_id;
			2'd2:    rsp_byte = is_read ? char_w'(1) : '0;
			default: rsp_byte = char_w'(snapshot);
		endcase
	end

	// Write ends at the length byte, read at the snapshot
	assign rsp_last = is_read ? (rsp_idx == 2'd3) : (rsp_idx == 2'd2);
	assign sl_data  = sl_arb_grant ? rsp_byte : '0;
	assign sl_tail  = sl_arb_grant && rsp_last;

endmodule

//--- source/ice_pkg.sv
package ice_pkg;

	// Character and baud divider widths
	localparam int char_w = 8;
	localparam int baud_w = 16;

	// Frame type characters
	// Version query, ASCII V
	localparam logic [char_w-1:0] type_version = 8'h56;
	// Baud divider set, ASCII b
	localparam logic [char_w-1:0] type_baud    = 8'h62;
	// GPIO write, ASCII G
	localparam logic [char_w-1:0] type_gpio_wr = 8'h47;
	// GPIO read, ASCII g
	localparam logic [char_w-1:0] type_gpio_rd = 8'h67;

	// First byte of every reply
	localparam logic [char_w-1:0] resp_ack = 8'h00;
	localparam logic [char_w-1:0] resp_nak = 8'h01;

	// Version reply payload
	localparam logic [char_w-1:0] version_major = 8'h00;
	localparam logic [char_w-1:0] version_minor = 8'h04;

endpackage

//--- source/ice_resp_arbiter.sv
`timescale 1ns/1ps

module ice_resp_arbiter #(
	parameter int num_dev = 2
) (
	input  logic                                     reset,
	input  logic                                     clk,
	input  logic [num_dev-1:0]                       sl_arb_request,
	output logic [num_dev-1:0]                       sl_arb_grant,
	input  logic [num_dev-1:0][ice_pkg::char_w-1:0]  sl_data,
	input  logic [num_dev-1:0]                       sl_tail,
	output logic                                     sl_latch,
	output logic [ice_pkg::char_w-1:0]               tx_data,
	output logic                                     tx_latch,
	input  logic                                     tx_empty
);
	import ice_pkg::*;

	logic [num_dev-1:0] pick;
	logic [char_w-1:0]  sel_data;
	logic               sel_tail;
	logic               busy;
	logic               fire;

	// Lowest set request bit wins
	assign pick = sl_arb_request & (~sl_arb_request + 1'b1);

	// Granted device's byte and tail flag
	always_comb begin
		sel_data = '0;
		sel_tail = 1'b0;
		for (int i = 0; i < num_dev; i++) begin
			if (sl_arb_grant[i]) begin
				sel_data = sl_data[i];
				sel_tail = sl_tail[i];
			end
		end
	end

	assign busy = |sl_arb_grant;
	// One character per empty transmitter
	assign fire     = busy && tx_empty;
	assign sl_latch = fire;
	assign tx_latch = fire;
	assign tx_data  = sel_data;

	// Grant moves only when free, released with the tail
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			sl_arb_grant <= '0;
		end else if (!busy) begin
			sl_arb_grant <= pick;
		end else if (fire && sel_tail) begin
			sl_arb_grant <= '0;
		end
	end

endmodule

//--- source/ice_uart.sv
`timescale 1ns/1ps

module ice_uart (
	input  logic                       reset,
	input  logic                       clk,
	input  logic [ice_pkg::baud_w-1:0] baud_div,
	input  logic                       rx_in,
	output logic                       tx_out,
	input  logic                       tx_latch,
	input  logic [ice_pkg::char_w-1:0] tx_data,
	output logic                       tx_empty,
	output logic [ice_pkg::char_w-1:0] rx_data,
	output logic                       rx_latch
);
	import ice_pkg::*;

	// Receiver state
	logic [1:0]        rx_sync;
	logic              rx_busy;
	logic [baud_w-1:0] rx_div;
	logic [baud_w-1:0] rx_cnt;
	logic [3:0]        rx_bit;
	logic [char_w-1:0] rx_shift;
	logic              rx_sample;

	// Transmitter state
	logic              tx_busy;
	logic [baud_w-1:0] tx_div;
	logic [baud_w-1:0] tx_cnt;
	logic [3:0]        tx_bit;
	logic [char_w+1:0] tx_shift;

	// Centre of the current bit
	assign rx_sample = rx_busy && rx_cnt == '0;

	// Two-flop synchronizer, line idles high
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			rx_sync <= 2'b11;
		end else begin
			rx_sync <= {rx_sync[0], rx_in};
		end
	end

	// Bit 0 is start, 1 to 8 data, 9 stop
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			rx_busy  <= 1'b0;
			rx_div   <= '0;
			rx_cnt   <= '0;
			rx_bit   <= '0;
			rx_latch <= 1'b0;
		end else begin
			rx_latch <= 1'b0;
			if (!rx_busy) begin
				// Start edge, half a bit to the centre
				if (!rx_sync[1]) begin
					rx_busy <= 1'b1;
					rx_div  <= baud_div;
					rx_cnt  <= baud_div >> 1;
					rx_bit  <= '0;
				end
			end else if (!rx_sample) begin
				rx_cnt <= rx_cnt - 1'b1;
			end else begin
				rx_cnt <= rx_div - 1'b1;
				rx_bit <= rx_bit + 1'b1;
				if (rx_bit == 4'd0 && rx_sync[1]) begin
					// Glitch, back to idle
					rx_busy <= 1'b0;
				end else if (rx_bit == 4'd9) begin
					rx_busy  <= 1'b0;
					// Framing error drops the character
					rx_latch <= rx_sync[1];
				end
			end
		end
	end

	// LSB arrives first
	always_ff @(posedge reset) begin
		if (rx_sample && rx_bit >= 4'd1 && rx_bit <= 4'd8) begin
			rx_shift <= {rx_sync[1], rx_shift[char_w-1:1]};
		end
		if (rx_sample && rx_bit == 4'd9) begin
			rx_data <= rx_shift;
		end
	end

	// Divider held per character, a rate change never splits one
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			tx_busy  <= 1'b0;
			tx_empty <= 1'b1;
			tx_div   <= '0;
			tx_cnt   <= '0;
			tx_bit   <= '0;
			tx_shift <= '1;
		end else begin
			// Empty again one cycle after the stop bit
			if (tx_latch) begin
				tx_empty <= 1'b0;
			end else if (!tx_busy) begin
				tx_empty <= 1'b1;
			end
			if (tx_latch && !tx_busy) begin
				tx_busy  <= 1'b1;
				tx_div   <= baud_div;
				tx_cnt   <= baud_div - 1'b1;
				tx_bit   <= '0;
				tx_shift <= {1'b1, tx_data, 1'b0};
			end else if (tx_busy) begin
				if (tx_cnt != '0) begin
					tx_cnt <= tx_cnt - 1'b1;
				end else begin
					tx_cnt   <= tx_div - 1'b1;
					tx_bit   <= tx_bit + 1'b1;
					tx_shift <= {1'b1, tx_shift[char_w+1:1]};
					if (tx_bit == 4'd9) begin
						tx_busy <= 1'b0;
					end
				end
			end
		end
	end

	// Idle shifter is all ones
	assign tx_out = tx_shift[0];

endmodule

//--- tb/ice_bus_sva.sv
`timescale 1ns/1ps

module ice_bus_sva #(
	parameter int num_dev = 2
) (
	input logic               reset,
	input logic               clk,
	input logic [num_dev-1:0] sl_arb_request,
	input logic [num_dev-1:0] sl_arb_grant,
	input logic               tx_latch,
	input logic               tx_empty
);

	// Failed assertions so far, watched from the testbench
	int fail_count = 0;

	// Never two devices granted at once
	grant_onehot: assert property (@(posedge reset) disable iff (clk)
		$onehot0(sl_arb_grant))
	else begin
		fail_count++;
		$error("Arbiter grant has more than one bit set");
	end

	// Grant only follows a held request
	grant_needs_request: assert property (@(posedge reset) disable iff (clk)
		(sl_arb_grant & ~sl_arb_request) == '0)
	else begin
		fail_count++;
		$error("Arbiter grant bit set without its request");
	end

	// Transmitter busy means no new character
	latch_when_empty: assert property (@(posedge reset) disable iff (clk)
		tx_latch |-> tx_empty)
	else begin
		fail_count++;
		$error("tx_latch pulsed while the transmitter was busy");
	end

endmodule

bind ice_resp_arbiter ice_bus_sva #(.num_dev(num_dev)) u_sva (
	.reset(reset),
	.clk(clk),
	.sl_arb_request(sl_arb_request),
	.sl_arb_grant(sl_arb_grant),
	.tx_latch(tx_latch),
	.tx_empty(tx_empty)
);

//--- tb/ice_bus_tb.sv
`timescale 1ns/1ps

module ice_bus_tb;

	// Reply codes and version bytes of the frame format
	localparam logic [7:0] ack_code      = 8'h00;
	localparam logic [7:0] nak_code      = 8'h01;
	localparam logic [7:0] version_major = 8'h00;
	localparam logic [7:0] version_minor = 8'h04;
	// Type characters V, b, G, g
	localparam logic [7:0] type_version  = 8'h56;
	localparam logic [7:0] type_baud     = 8'h62;
	localparam logic [7:0] type_gpio_wr  = 8'h47;
	localparam logic [7:0] type_gpio_rd  = 8'h67;
	// About 60 characters of 80 cycles, plus wide margin
	localparam int         timeout_cycles = 60000;

	logic       reset;
	logic       clk;
	logic       rx_in;
	logic       tx_out;
	logic [7:0] gpio_in;
	logic [7:0] gpio_out;
	logic [7:0] gpio_oe;

	// Host side bit time in clocks
	int         host_div;
	int         cycle_count = 0;
	int         fail_count = 0;
	int         seed_value;
	// Last written GPIO registers
	logic [7:0] exp_oe;
	logic [7:0] exp_out;

	ice_bus #(.num_dev(2), .gpio_w(8), .default_baud_div(16'd8)) uut (
		.reset(reset),
		.clk(clk),
		.rx_in(rx_in),
		.tx_out(tx_out),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out),
		.gpio_oe(gpio_oe)
	);

	// 10 ns clock on the reset port
	initial begin
		reset = 1'b0;
		forever #5 reset = ~reset;
	end

	task automatic report_failure(input string msg);
		fail_count++;
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_value(input logic [7:0] got, input logic [7:0] exp, input string name);
		assert (got === exp) else begin
			report_failure($sformatf("Mismatch at time %0t: %s expected 0x%02h, got 0x%02h",
				$time, name, exp, got));
		end
	endtask

	// Host transmitter, 8N1, LSB first
	task automatic send_char(input logic [7:0] value);
		int i;
		rx_in = 1'b0;
		repeat (host_div) @(negedge reset);
		for (i = 0; i < 8; i++) begin
			rx_in = value[i];
			repeat (host_div) @(negedge reset);
		end
		rx_in = 1'b1;
		repeat (host_div) @(negedge reset);
	endtask

	// Host receiver, samples near each bit centre
	task automatic recv_char(output logic [7:0] value);
		int i;
		do begin
			@(negedge reset);
		end while (tx_out !== 1'b0);
		repeat (host_div / 2 - 1) @(negedge reset);
		assert (tx_out === 1'b0) else report_failure("Start bit on tx_out ended early");
		for (i = 0; i < 8; i++) begin
			repeat (host_div) @(negedge reset);
			value[i] = tx_out;
		end
		repeat (host_div) @(negedge reset);
		assert (tx_out === 1'b1) else report_failure("Stop bit missing on tx_out");
	endtask

	// Type, id, length, then up to two payload bytes
	task automatic send_frame(input logic [7:0] ftype, input logic [7:0] id,
		input logic [7:0] len, input logic [7:0] p0, input logic [7:0] p1);
		send_char(ftype);
		send_char(id);
		send_char(len);
		if (len > 0) begin
			send_char(p0);
		end
		if (len > 1) begin
			send_char(p1);
		end
	endtask

	task automatic expect_reply(input logic [7:0] code, input logic [7:0] id,
		input logic [7:0] len, input logic [7:0] p0, input logic [7:0] p1);
		logic [7:0] got;
		recv_char(got);
		check_value(got, code, "tx_out reply code");
		recv_char(got);
		check_value(got, id, "tx_out reply id");
		recv_char(got);
		check_value(got, len, "tx_out reply length");
		if (len > 0) begin
			recv_char(got);
			check_value(got, p0, "tx_out reply payload byte 0");
		end
		if (len > 1) begin
			recv_char(got);
			check_value(got, p1, "tx_out reply payload byte 1");
		end
	endtask

	// Receiver listens while the frame goes out
	task automatic exchange(input logic [7:0] ftype, input logic [7:0] id,
		input logic [7:0] len, input logic [7:0] p0, input logic [7:0] p1,
		input logic [7:0] rcode, input logic [7:0] rlen, input logic [7:0] r0);
		fork
			send_frame(ftype, id, len, p0, p1);
			expect_reply(rcode, id, rlen, r0, 8'h00);
		join
	endtask

	task automatic version_query();
		logic [7:0] id;
		id = 8'($urandom());
		fork
			send_frame(type_version, id, 8'd0, 8'h00, 8'h00);
			expect_reply(ack_code, id, 8'd2, version_major, version_minor);
		join
	endtask

	task automatic gpio_write();
		logic [7:0] id;
		id = 8'($urandom());
		exp_oe = 8'($urandom());
		exp_out = 8'($urandom());
		exchange(type_gpio_wr, id, 8'd2, exp_oe, exp_out, ack_code, 8'd0, 8'h00);
		check_value(gpio_oe, exp_oe, "gpio_oe");
		check_value(gpio_out, exp_out, "gpio_out");
	endtask

	task automatic gpio_read();
		logic [7:0] id;
		logic [7:0] pins;
		id = 8'($urandom());
		pins = 8'($urandom());
		gpio_in = pins;
		exchange(type_gpio_rd, id, 8'd0, 8'h00, 8'h00, ack_code, 8'd1, pins);
	endtask

	task automatic unknown_type();
		logic [7:0] id;
		logic [7:0] ftype;
		id = 8'($urandom());
		// Any type nobody owns
		do begin
			ftype = 8'($urandom());
		end while (ftype == type_version || ftype == type_baud ||
			ftype == type_gpio_wr || ftype == type_gpio_rd);
		exchange(ftype, id, 8'd2, 8'($urandom()), 8'($urandom()), nak_code, 8'd0, 8'h00);
		check_value(gpio_oe, exp_oe, "gpio_oe");
		check_value(gpio_out, exp_out, "gpio_out");
	endtask

	task automatic baud_change();
		logic [7:0] id;
		id = 8'($urandom());
		// Divider 4, high byte first, ACK still at 8
		exchange(type_baud, id, 8'd2, 8'h00, 8'h04, ack_code, 8'd0, 8'h00);
		host_div = 4;
		version_query();
	endtask

	task automatic back_to_back();
		logic [7:0] id_read;
		logic [7:0] id_ver;
		logic [7:0] pins;
		id_read = 8'($urandom());
		id_ver = 8'($urandom());
		pins = 8'($urandom());
		gpio_in = pins;
		fork
			begin
				send_frame(type_gpio_rd, id_read, 8'd0, 8'h00, 8'h00);
				send_frame(type_version, id_ver, 8'd0, 8'h00, 8'h00);
			end
			begin
				// GPIO claimed first, so it answers first
				expect_reply(ack_code, id_read, 8'd1, pins, 8'h00);
				expect_reply(ack_code, id_ver, 8'd2, version_major, version_minor);
			end
		join
	endtask

	// Watchdog and bound assertion monitor
	always @(posedge reset) begin
		cycle_count++;
		assert (uut.u_arbiter.u_sva.fail_count == 0)
		else report_failure("Assertion in the response arbiter failed");
		assert (cycle_count < timeout_cycles)
		else report_failure("Timeout, DUT reply did not complete in time");
	end

	initial begin
		seed_value = $urandom(94473);
		clk = 1'b1;
		rx_in = 1'b1;
		gpio_in = 8'h00;
		host_div = 8;
		exp_oe = 8'h00;
		exp_out = 8'h00;
		// Three clock cycles of reset
		repeat (3) @(negedge reset);
		clk = 1'b0;
		@(negedge reset);
		assert (tx_out === 1'b1) else report_failure("tx_out not idle after reset");
		check_value(gpio_oe, 8'h00, "gpio_oe");
		version_query();
		gpio_write();
		gpio_read();
		unknown_type();
		baud_change();
		back_to_back();
		// Arbiter assertions of the last cycle count too
		if (fail_count == 0 && uut.u_arbiter.u_sva.fail_count == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			report_failure("Errors were found during the run");
		end
	end

endmodule
